//--- rtl/ap_pkg.sv
`default_nettype none

package ap_pkg;

    // Datapath and instruction field widths
    localparam int DATA_W     = 8;              // Byte and array row width
    localparam int ROWS       = 16;             // Rows per associative field
    localparam int ROW_IDX_W  = $clog2(ROWS);   // Row index inside one field
    localparam int ROW_ADDR_W = 8;
    localparam int MEM_ADDR_W = 16;
    localparam int OP_W       = 4;
    localparam int SEL_W      = 2;

    // Default store depths, overridden from the top level
    localparam int PROG_DEPTH_DEF = 64;
    localparam int MEM_DEPTH_DEF  = 128;        // Addresses wrap modulo this

    typedef logic [DATA_W-1:0] ap_data_t;

    // Opcode codes of the instruction set, gaps are no-ops
    typedef enum logic [OP_W-1:0] {
        OP_NOP      = 4'd0,     // Any undefined code behaves like this
        OP_RESET    = 4'd1,     // Clear A, B and R
        OP_RET      = 4'd2,     // End of program
        OP_LOADRBR  = 4'd4,     // Memory byte into one row
        OP_STORERBR = 4'd6,     // One row into memory
        OP_COPY     = 4'd8,     // Whole field to field
        OP_ADD      = 4'd9,     // R = A + B
        OP_SUB      = 4'd10,    // R = A - B
        OP_TSC      = 4'd11,    // R = -A
        OP_ABS      = 4'd12     // R = |A|
    } ap_opcode_e;

    typedef enum logic [SEL_W-1:0] {
        FLD_NONE = 2'd0,
        FLD_A    = 2'd1,
        FLD_B    = 2'd2,
        FLD_R    = 2'd3
    } ap_field_e;

    // Instruction word, 30 bits, opcode in the MSBs
    typedef struct packed {
        ap_opcode_e             opcode;
        logic [ROW_ADDR_W-1:0]  row;    // Row index, low bits give COPY source field
        ap_field_e              sel;    // Target field, COPY destination
        logic [MEM_ADDR_W-1:0]  addr;   // Data store byte address
    } ap_instr_t;

    // Sequencer to array command
    typedef struct packed {
        ap_opcode_e             op;
        logic [ROW_IDX_W-1:0]   row;
        ap_field_e              dst;
        ap_field_e              src;
        ap_data_t               wdata;  // Row byte for LOADRBR
    } ap_array_cmd_t;

    // Core side access to the data store
    typedef struct packed {
        logic                   we;     // Write when set, read otherwise
        logic [MEM_ADDR_W-1:0]  addr;
        ap_data_t               wdata;
    } ap_mem_req_t;

endpackage

`default_nettype wire

//--- rtl/ap_instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module ap_instr_mem #(
    parameter int PROG_DEPTH = ap_pkg::PROG_DEPTH_DEF
) (
    input  logic                          sys_clk_i,
    input  logic                          wr_i,          // Host write strobe
    input  logic [$clog2(PROG_DEPTH)-1:0] wr_addr_i,
    input  ap_pkg::ap_instr_t             wr_instr_i,
    input  logic [$clog2(PROG_DEPTH)-1:0] rd_addr_i,     // Program counter
    output ap_pkg::ap_instr_t             rd_instr_o
);

    import ap_pkg::*;

    // Program storage, kept across runs
    ap_instr_t prog_q [PROG_DEPTH];
    ap_instr_t rd_q;

    always_ff @(posedge sys_clk_i) begin
        if (wr_i) begin
            prog_q[wr_addr_i] <= wr_instr_i;   // One word per strobe
        end
    end

    // Registered fetch, word shows one cycle after the address
    always_ff @(posedge sys_clk_i) begin
        rd_q <= prog_q[rd_addr_i];
    end

    assign rd_instr_o = rd_q;

endmodule

`default_nettype wire

//--- rtl/ap_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module ap_data_mem #(
    parameter int MEM_DEPTH = ap_pkg::MEM_DEPTH_DEF
) (
    input  logic                          sys_clk_i,
    input  logic                          host_wr_i,       // Gated by busy at the top
    input  logic [ap_pkg::MEM_ADDR_W-1:0] host_addr_i,
    input  ap_pkg::ap_data_t              host_data_i,
    input  logic [ap_pkg::MEM_ADDR_W-1:0] host_rd_addr_i,
    output ap_pkg::ap_data_t              host_rd_data_o,
    input  logic                          core_valid_i,
    input  ap_pkg::ap_mem_req_t           core_req_i,
    output ap_pkg::ap_data_t              core_rd_data_o
);

    import ap_pkg::*;

    localparam int MA_W = $clog2(MEM_DEPTH);   // Address bits kept, rest wraps

    ap_data_t mem_q [MEM_DEPTH];
    ap_data_t host_rd_q;
    ap_data_t core_rd_q;

    // Host and core writes never overlap in time
    always_ff @(posedge sys_clk_i) begin
        if (host_wr_i) begin
            mem_q[host_addr_i[MA_W-1:0]] <= host_data_i;
        end
        if (core_valid_i && core_req_i.we) begin
            mem_q[core_req_i.addr[MA_W-1:0]] <= core_req_i.wdata;   // STORERBR
        end
    end

    // Both read paths registered
    always_ff @(posedge sys_clk_i) begin
        host_rd_q <= mem_q[host_rd_addr_i[MA_W-1:0]];
        if (core_valid_i && !core_req_i.we) begin
            core_rd_q <= mem_q[core_req_i.addr[MA_W-1:0]];       // Held for LOADRBR
        end
    end

    assign host_rd_data_o = host_rd_q;
    assign core_rd_data_o = core_rd_q;

endmodule

`default_nettype wire

//--- rtl/ap_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ap_sequencer #(
    parameter int PROG_DEPTH = ap_pkg::PROG_DEPTH_DEF,
    parameter int MEM_DEPTH  = ap_pkg::MEM_DEPTH_DEF
) (
    input  logic                          sys_clk_i,
    input  logic                          reset_i,
    input  logic                          start_i,        // Already gated by busy
    output logic [$clog2(PROG_DEPTH)-1:0] pc_o,
    input  ap_pkg::ap_instr_t             instr_i,        // Word at pc_o, one cycle late
    output logic                          cmd_valid_o,
    output ap_pkg::ap_array_cmd_t         cmd_o,
    input  logic                          cmd_done_i,
    input  ap_pkg::ap_data_t              row_data_i,
    output logic                          mem_valid_o,
    output ap_pkg::ap_mem_req_t           mem_req_o,
    input  ap_pkg::ap_data_t              mem_rd_data_i,
    output logic                          busy_o,
    output logic                          done_o
);

    import ap_pkg::*;

    localparam int PA_W = $clog2(PROG_DEPTH);
    localparam int MA_W = $clog2(MEM_DEPTH);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,          // Instruction store read in flight
        DECODE,         // instr_i valid, first strobe issued
        MEM_READ,       // Byte back from memory, array write issued
        ARRAY_WAIT,     // Waiting on cmd_done
        MEM_WRITE       // Row byte into memory
    } state_e;

    state_e          state_q;
    logic [PA_W-1:0] pc_q;
    logic            busy_q;
    logic            done_q;
    ap_opcode_e      eff_op;    // Opcode after NONE field folding

    // Load or store with no field does nothing
    always_comb begin
        eff_op = instr_i.opcode;
        if ((eff_op == OP_LOADRBR || eff_op == OP_STORERBR) && instr_i.sel == FLD_NONE) begin
            eff_op = OP_NOP;
        end
    end

    // pc stays put until the instruction ends, so instr_i holds throughout
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            pc_q    <= '0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        pc_q    <= '0;     // Program always starts at word 0
                        busy_q  <= 1'b1;
                        state_q <= FETCH;
                    end
                end
                FETCH: state_q <= DECODE;
                DECODE: begin
                    case (eff_op)
                        OP_RET: begin
                            busy_q  <= 1'b0;   // Falls with the done pulse
                            done_q  <= 1'b1;
                            state_q <= IDLE;
                        end
                        OP_LOADRBR: state_q <= MEM_READ;
                        default:    state_q <= ARRAY_WAIT;   // Row, arith and no-op
                    endcase
                end
                MEM_READ: state_q <= ARRAY_WAIT;
                ARRAY_WAIT: begin
                    if (cmd_done_i) begin
                        if (eff_op == OP_STORERBR) begin
                            state_q <= MEM_WRITE;
                        end else begin
                            pc_q    <= pc_q + 1'b1;   // Wraps at PROG_DEPTH
                            state_q <= FETCH;
                        end
                    end
                end
                MEM_WRITE: begin
                    pc_q    <= pc_q + 1'b1;
                    state_q <= FETCH;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Strobes and payloads decoded from state and the current word
    always_comb begin
        cmd_valid_o     = 1'b0;
        mem_valid_o     = 1'b0;
        cmd_o.op        = eff_op;
        cmd_o.row       = instr_i.row[ROW_IDX_W-1:0];
        cmd_o.dst       = instr_i.sel;
        // COPY names its source in the row field
        cmd_o.src       = (eff_op == OP_COPY) ? ap_field_e'(instr_i.row[SEL_W-1:0])
                                              : instr_i.sel;
        cmd_o.wdata     = mem_rd_data_i;
        mem_req_o.we    = (state_q == MEM_WRITE);
        mem_req_o.addr  = MEM_ADDR_W'(instr_i.addr[MA_W-1:0]);
        mem_req_o.wdata = row_data_i;            // Row read held by the array
        case (state_q)
            DECODE: begin
                mem_valid_o = (eff_op == OP_LOADRBR);
                cmd_valid_o = (eff_op != OP_LOADRBR) && (eff_op != OP_RET);
            end
            MEM_READ:  cmd_valid_o = 1'b1;       // Array write of the loaded byte
            MEM_WRITE: mem_valid_o = 1'b1;
            default: ;
        endcase
    end

    assign pc_o   = pc_q;
    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

`default_nettype wire

//--- rtl/ap_assoc_array.sv
`timescale 1ns/1ps
`default_nettype none

module ap_assoc_array (
    input  logic                  sys_clk_i,
    input  logic                  reset_i,
    input  logic                  cmd_valid_i,
    input  ap_pkg::ap_array_cmd_t cmd_i,
    output logic                  cmd_done_o,    // One cycle pulse per command
    output ap_pkg::ap_data_t      row_data_o
);

    import ap_pkg::*;

    localparam int COL_W = $clog2(DATA_W);

    // Fields indexed by their ap_field_e code, NONE has no storage
    ap_data_t        fld_q [1:3][ROWS];
    ap_data_t        row_q;          // Last STORERBR row
    logic [ROWS-1:0] carry_q;        // Carry column, one bit per row

    logic             run_q;         // Arithmetic pass past column 0
    logic             done_q;
    logic [COL_W-1:0] col_q;         // Next column to process
    ap_opcode_e       op_q;

    ap_opcode_e       cur_op;
    logic [COL_W-1:0] cur_col;
    logic             step;          // A column is processed this cycle
    logic             use_b;
    logic             inv_b;
    logic [ROWS-1:0]  inv_a;
    logic [ROWS-1:0]  cin;
    logic [ROWS-1:0]  a_bit;
    logic [ROWS-1:0]  b_bit;
    logic [ROWS-1:0]  sum_bit;
    logic [ROWS-1:0]  cout;

    // Column 0 runs on the strobe edge, later ones from the held op
    always_comb begin
        cur_op  = cmd_valid_i ? cmd_i.op : op_q;
        cur_col = cmd_valid_i ? '0 : col_q;
        step    = cmd_valid_i ? (cmd_i.op inside {OP_ADD, OP_SUB, OP_TSC, OP_ABS}) : run_q;
        use_b   = (cur_op == OP_ADD) || (cur_op == OP_SUB);
        inv_b   = (cur_op == OP_SUB);                     // A + ~B + 1
        for (int r = 0; r < ROWS; r++) begin
            case (cur_op)
                OP_TSC:  inv_a[r] = 1'b1;                 // ~A + 1
                OP_ABS:  inv_a[r] = fld_q[FLD_A][r][DATA_W-1];   // Negate only if signed
                default: inv_a[r] = 1'b0;
            endcase
            // Seed carry holds the +1 of every negation
            cin[r]     = cmd_valid_i ? (inv_a[r] | inv_b) : carry_q[r];
            a_bit[r]   = fld_q[FLD_A][r][cur_col] ^ inv_a[r];
            b_bit[r]   = (fld_q[FLD_B][r][cur_col] ^ inv_b) & use_b;
            sum_bit[r] = a_bit[r] ^ b_bit[r] ^ cin[r];
            cout[r]    = (a_bit[r] & b_bit[r]) | (cin[r] & (a_bit[r] ^ b_bit[r]));
        end
    end

    // Control, cleared by reset
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            col_q  <= '0;
            op_q   <= OP_NOP;
        end else begin
            done_q <= 1'b0;
            if (cmd_valid_i) begin
                if (cmd_i.op inside {OP_ADD, OP_SUB, OP_TSC, OP_ABS}) begin
                    run_q <= 1'b1;
                    op_q  <= cmd_i.op;
                    col_q <= COL_W'(1);
                end else begin
                    done_q <= 1'b1;              // Row commands finish in one edge
                end
            end else if (run_q) begin
                col_q <= col_q + 1'b1;
                if (col_q == COL_W'(DATA_W - 1)) begin
                    run_q  <= 1'b0;              // MSB column just written
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Field contents and carry column
    always_ff @(posedge sys_clk_i) begin
        if (cmd_valid_i) begin
            case (cmd_i.op)
                OP_RESET: begin
                    for (int f = 1; f <= 3; f++) begin
                        for (int r = 0; r < ROWS; r++) begin
                            fld_q[f][r] <= '0;
                        end
                    end
                end
                OP_LOADRBR: begin
                    if (cmd_i.dst != FLD_NONE) fld_q[cmd_i.dst][cmd_i.row] <= cmd_i.wdata;
                end
                OP_STORERBR: begin
                    row_q <= (cmd_i.src != FLD_NONE) ? fld_q[cmd_i.src][cmd_i.row] : '0;
                end
                OP_COPY: begin
                    if (cmd_i.dst != FLD_NONE && cmd_i.src != FLD_NONE) begin
                        for (int r = 0; r < ROWS; r++) begin
                            fld_q[cmd_i.dst][r] <= fld_q[cmd_i.src][r];
                        end
                    end
                end
                default: ;                           // Arithmetic handled below
            endcase
        end
        if (step) begin
            for (int r = 0; r < ROWS; r++) begin
                fld_q[FLD_R][r][cur_col] <= sum_bit[r];   // All rows in parallel
                carry_q[r]               <= cout[r];
            end
        end
    end

    assign cmd_done_o = done_q;
    assign row_data_o = row_q;

endmodule

`default_nettype wire

//--- rtl/ap_top.sv
`timescale 1ns/1ps
`default_nettype none

module ap_top #(
    parameter int PROG_DEPTH = ap_pkg::PROG_DEPTH_DEF,
    parameter int MEM_DEPTH  = ap_pkg::MEM_DEPTH_DEF
) (
    input  logic                          sys_clk_i,
    input  logic                          reset_i,
    input  logic                          prog_wr_i,
    input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr_i,
    input  ap_pkg::ap_instr_t             prog_instr_i,
    input  logic                          data_wr_i,
    input  logic [ap_pkg::MEM_ADDR_W-1:0] data_addr_i,
    input  ap_pkg::ap_data_t              data_i,
    input  logic                          start_i,
    input  logic [ap_pkg::MEM_ADDR_W-1:0] rd_addr_i,
    output ap_pkg::ap_data_t              rd_data_o,     // Registered readback
    output logic                          busy_o,
    output logic                          done_o
);

    import ap_pkg::*;

    logic                          busy;
    logic [$clog2(PROG_DEPTH)-1:0] pc;
    ap_instr_t                     instr;
    logic                          cmd_valid;
    ap_array_cmd_t                 cmd;
    logic                          cmd_done;
    ap_data_t                      row_data;
    logic                          mem_valid;
    ap_mem_req_t                   mem_req;
    ap_data_t                      mem_rd_data;

    // Host strobes are dropped while a program runs
    ap_instr_mem #(.PROG_DEPTH(PROG_DEPTH)) u_instr_mem (
        .sys_clk_i  (sys_clk_i),
        .wr_i       (prog_wr_i & ~busy),
        .wr_addr_i  (prog_addr_i),
        .wr_instr_i (prog_instr_i),
        .rd_addr_i  (pc),
        .rd_instr_o (instr)
    );

    ap_data_mem #(.MEM_DEPTH(MEM_DEPTH)) u_data_mem (
        .sys_clk_i      (sys_clk_i),
        .host_wr_i      (data_wr_i & ~busy),
        .host_addr_i    (data_addr_i),
        .host_data_i    (data_i),
        .host_rd_addr_i (rd_addr_i),
        .host_rd_data_o (rd_data_o),
        .core_valid_i   (mem_valid),
        .core_req_i     (mem_req),
        .core_rd_data_o (mem_rd_data)
    );

    ap_sequencer #(.PROG_DEPTH(PROG_DEPTH), .MEM_DEPTH(MEM_DEPTH)) u_sequencer (
        .sys_clk_i     (sys_clk_i),
        .reset_i       (reset_i),
        .start_i       (start_i & ~busy),   // No restart mid-run
        .pc_o          (pc),
        .instr_i       (instr),
        .cmd_valid_o   (cmd_valid),
        .cmd_o         (cmd),
        .cmd_done_i    (cmd_done),
        .row_data_i    (row_data),
        .mem_valid_o   (mem_valid),
        .mem_req_o     (mem_req),
        .mem_rd_data_i (mem_rd_data),
        .busy_o        (busy),
        .done_o        (done_o)
    );

    ap_assoc_array u_assoc_array (
        .sys_clk_i   (sys_clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .cmd_done_o  (cmd_done),
        .row_data_o  (row_data)
    );

    assign busy_o = busy;

endmodule

`default_nettype wire

//--- sim/ap_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ap_chk (
    input logic sys_clk_i,
    input logic reset_i,
    input logic start_i,    // Raw host strobe
    input logic busy_i,
    input logic done_i
);

    // Done is a one cycle pulse
    a_done_pulse: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        done_i |=> !done_i)
        else $error("done_o high on two cycles in a row");

    a_done_idle: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        done_i |-> !busy_i)   // Busy falls on the done edge
        else $error("done_o high while busy_o is high");

    // A run begins only from a start strobe
    a_busy_start: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        $rose(busy_i) |-> $past(start_i))
        else $error("busy_o rose without start_i");

endmodule

bind ap_top ap_chk u_ap_chk (
    .sys_clk_i (sys_clk_i),
    .reset_i   (reset_i),
    .start_i   (start_i),
    .busy_i    (busy_o),
    .done_i    (done_o)
);

`default_nettype wire

//--- sim/tb_ap_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ap_top;

    import ap_pkg::*;

    localparam int PA_W      = $clog2(PROG_DEPTH_DEF);
    localparam int NCASE     = 15;
    localparam int TIMEOUT   = 2000;    // Cycles allowed per run
    localparam int BUSY_ADDR = 100;     // Written while busy, must keep its byte
    localparam int MID_ADDR  = 90;      // Address field of the middle instruction
    localparam ap_data_t CORNER [4] = '{8'h00, 8'h7F, 8'h80, 8'hFF};

    // One stimulus table row
    typedef struct packed {
        ap_opcode_e op;      // Middle instruction
        ap_field_e  sel;     // Its field, COPY destination
        ap_field_e  src;     // COPY source, goes in the row field
        ap_field_e  ld2;     // Loaded from bytes 16..31
        ap_field_e  st;      // Stored to bytes 64..79
        logic       corner;  // Corner bytes instead of LFSR bytes
    } case_t;

    logic                  sys_clk_i = 1'b0;
    logic                  reset_i;
    logic                  prog_wr_i;
    logic [PA_W-1:0]       prog_addr_i;
    ap_instr_t             prog_instr_i;
    logic                  data_wr_i;
    logic [MEM_ADDR_W-1:0] data_addr_i;
    ap_data_t              data_i;
    logic                  start_i;
    logic [MEM_ADDR_W-1:0] rd_addr_i;
    ap_data_t              rd_data_o;
    logic                  busy_o;
    logic                  done_o;

    case_t       cases [NCASE];
    ap_data_t    mem_m [MEM_DEPTH_DEF];   // Reference data store
    ap_data_t    fld_m [4][ROWS];         // Reference fields by code, 0 unused
    logic [31:0] lfsr_q;
    int          done_cnt;

    ap_top #(.PROG_DEPTH(PROG_DEPTH_DEF), .MEM_DEPTH(MEM_DEPTH_DEF)) u_ap_top (.*);

    always #50 sys_clk_i = ~sys_clk_i;

    always @(negedge sys_clk_i) begin
        if (done_o) done_cnt <= done_cnt + 1;   // Pulses seen so far
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input ap_data_t got, input ap_data_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED at %0t: %s got 0x%02h, expected 0x%02h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED at %0t: %s got %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic ap_data_t rand_byte();
        ap_data_t v;
        v = '0;
        for (int i = 0; i < DATA_W; i++) begin
            v = {v[DATA_W-2:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    task automatic write_byte(input int addr, input ap_data_t val);
        @(posedge sys_clk_i);
        data_wr_i   <= 1'b1;
        data_addr_i <= MEM_ADDR_W'(addr);
        data_i      <= val;
        @(posedge sys_clk_i);
        data_wr_i   <= 1'b0;
    endtask

    task automatic write_instr(input int pc, input ap_opcode_e op, input int row,
                               input ap_field_e sel, input int addr);
        ap_instr_t w;
        w.opcode = op;
        w.row    = ROW_ADDR_W'(row);
        w.sel    = sel;
        w.addr   = MEM_ADDR_W'(addr);
        @(posedge sys_clk_i);
        prog_wr_i    <= 1'b1;
        prog_addr_i  <= PA_W'(pc);
        prog_instr_i <= w;
        @(posedge sys_clk_i);
        prog_wr_i    <= 1'b0;
    endtask

    // Readback is registered, byte shows one cycle after the address
    task automatic read_check(input int addr);
        @(posedge sys_clk_i);
        rd_addr_i <= MEM_ADDR_W'(addr);
        @(posedge sys_clk_i);
        @(negedge sys_clk_i);
        check_data($sformatf("rd_data_o[%0d]", addr), rd_data_o, mem_m[addr]);
    endtask

    // Field effect of the middle instruction, straight from the instruction rules
    function automatic void model_op(input case_t c);
        ap_data_t a;
        for (int r = 0; r < ROWS; r++) begin
            a = fld_m[FLD_A][r];
            case (c.op)
                OP_ADD:   fld_m[FLD_R][r] = a + fld_m[FLD_B][r];
                OP_SUB:   fld_m[FLD_R][r] = a - fld_m[FLD_B][r];
                OP_TSC:   fld_m[FLD_R][r] = 8'd0 - a;
                OP_ABS:   fld_m[FLD_R][r] = a[DATA_W-1] ? 8'd0 - a : a;   // 0x80 stays
                OP_COPY:  fld_m[c.sel][r] = fld_m[c.src][r];
                OP_RESET: for (int f = 1; f < 4; f++) fld_m[f][r] = '0;
                default: ;                                  // NONE loads and stores too
            endcase
        end
    endfunction

    task automatic run_case(input int n, input case_t c);
        int t;
        for (int r = 0; r < ROWS; r++) begin
            mem_m[r]        = c.corner ? CORNER[r % 4] : rand_byte();   // A operands
            mem_m[ROWS + r] = c.corner ? CORNER[r / 4] : rand_byte();   // All 16 pairs
        end
        for (int i = 0; i < 2 * ROWS; i++) write_byte(i, mem_m[i]);
        // Load A, load ld2, middle word, store st, RET
        for (int r = 0; r < ROWS; r++) begin
            write_instr(r, OP_LOADRBR, r, FLD_A, r);
            write_instr(ROWS + r, OP_LOADRBR, r, c.ld2, ROWS + r);
            write_instr(2 * ROWS + 1 + r, OP_STORERBR, r, c.st, 64 + r);
        end
        write_instr(2 * ROWS, c.op, int'(c.src), c.sel, MID_ADDR);
        write_instr(3 * ROWS + 1, OP_RET, 0, FLD_NONE, 0);
        for (int r = 0; r < ROWS; r++) begin
            fld_m[FLD_A][r] = mem_m[r];
            fld_m[c.ld2][r] = mem_m[ROWS + r];
        end
        model_op(c);
        for (int r = 0; r < ROWS; r++) mem_m[64 + r] = fld_m[c.st][r];
        @(posedge sys_clk_i);
        start_i <= 1'b1;
        @(posedge sys_clk_i);
        start_i <= 1'b0;
        @(negedge sys_clk_i);
        check_bit("busy_o after start", busy_o, 1'b1);
        write_byte(BUSY_ADDR, ~mem_m[BUSY_ADDR]);   // Dropped by the busy gate
        t = 0;
        while (done_cnt == n && t < TIMEOUT) begin
            @(negedge sys_clk_i);
            t++;
        end
        if (done_cnt == n) fail_stop($sformatf("Timeout waiting for done_o in case %0d", n));
        check_bit("busy_o at done", busy_o, 1'b0);
        repeat (3) @(negedge sys_clk_i);
        check_bit("one done_o pulse per start", done_cnt == n + 1, 1'b1);
        for (int a = 0; a < MEM_DEPTH_DEF; a++) read_check(a);   // Whole store vs model
    endtask

    initial begin
        reset_i      = 1'b1;
        prog_wr_i    = 1'b0;
        prog_addr_i  = '0;
        prog_instr_i = '0;
        data_wr_i    = 1'b0;
        data_addr_i  = '0;
        data_i       = '0;
        start_i      = 1'b0;
        rd_addr_i    = '0;
        lfsr_q       = 32'h80efaafd;
        done_cnt     = 0;
        cases = '{
            '{OP_NOP,   FLD_NONE, FLD_NONE, FLD_B, FLD_A, 1'b0},   // Plain load and store
            '{OP_NOP,   FLD_NONE, FLD_NONE, FLD_B, FLD_B, 1'b1},
            '{OP_NOP,   FLD_NONE, FLD_NONE, FLD_R, FLD_R, 1'b0},
            '{OP_ADD,   FLD_NONE, FLD_NONE, FLD_B, FLD_R, 1'b0},
            '{OP_ADD,   FLD_NONE, FLD_NONE, FLD_B, FLD_R, 1'b1},
            '{OP_SUB,   FLD_NONE, FLD_NONE, FLD_B, FLD_R, 1'b0},
            '{OP_SUB,   FLD_NONE, FLD_NONE, FLD_B, FLD_R, 1'b1},
            '{OP_TSC,   FLD_NONE, FLD_NONE, FLD_B, FLD_R, 1'b1},
            '{OP_ABS,   FLD_NONE, FLD_NONE, FLD_B, FLD_R, 1'b0},
            '{OP_ABS,   FLD_NONE, FLD_NONE, FLD_B, FLD_R, 1'b1},
            '{OP_COPY,  FLD_B,    FLD_A,    FLD_B, FLD_B, 1'b0},   // B takes A
            '{OP_RESET, FLD_NONE, FLD_NONE, FLD_B, FLD_A, 1'b0},
            '{ap_opcode_e'(4'd5), FLD_A, FLD_NONE, FLD_R, FLD_R, 1'b0},   // Undefined code
            '{OP_LOADRBR,  FLD_NONE, FLD_NONE, FLD_R, FLD_R, 1'b1},
            '{OP_STORERBR, FLD_NONE, FLD_NONE, FLD_B, FLD_A, 1'b0}        // Byte 90 kept
        };
        repeat (5) @(posedge sys_clk_i);
        reset_i <= 1'b0;
        @(negedge sys_clk_i);
        check_bit("busy_o after reset", busy_o, 1'b0);
        check_bit("done_o after reset", done_o, 1'b0);
        // Fill the whole store, odd multiplier keeps every byte distinct
        for (int a = 0; a < MEM_DEPTH_DEF; a++) begin
            mem_m[a] = ap_data_t'(a * 37) ^ 8'h5A;
            write_byte(a, mem_m[a]);
        end
        for (int a = 0; a < MEM_DEPTH_DEF; a++) read_check(a);
        for (int n = 0; n < NCASE; n++) run_case(n, cases[n]);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/ap_pkg.sv
rtl/ap_instr_mem.sv
rtl/ap_data_mem.sv
rtl/ap_sequencer.sv
rtl/ap_assoc_array.sv
rtl/ap_top.sv
sim/ap_chk.sv
sim/tb_ap_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, sim.log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ap_top \
    -f files.f -o tb_ap_top_sim > sim.log 2>&1 &&
    ./obj_dir/tb_ap_top_sim >> sim.log 2>&1
cat sim.log
! grep -q "Errors found" sim.log && grep -q "No errors" sim.log
